/* verilog.f */
source/z80tube_pkg.sv
source/host_bus_interface.sv
source/tube_cycle_sequencer.sv
source/bridge_control_regs.sv
source/z80tube_top.sv
verification/tube_parasite_model.sv
verification/z80tube_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Z80 to Tube bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  --top-module z80tube_tb \
  -f verilog.f \
  -o z80tube_sim

./obj_dir/z80tube_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Testbench reported a failure, see sim.log"
  exit 1
fi

echo "Run complete, log in sim.log"

/* verification/z80tube_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module z80tube_tb import z80tube_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  // Upper bound on the clock cycles of any one test
  localparam int TEST_CYCLES  = 1000;
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * NUM_TESTS * CLK_PERIOD;

  logic        CLK;
  logic        reset_b_w;
  host_bus_t   host;
  logic [7:0]  data_in;
  logic [7:0]  tube_data_in;
  logic        tube_int_b;
  logic [7:0]  data_out;
  logic        data_oe;
  logic        int_b;
  tube_bus_t   tube;
  logic [7:0]  tube_data_out;
  logic        tube_data_oe;
  logic [31:0] phi2_count;
  logic [31:0] write_count;

  // Reference copy of the Tube registers and the status byte
  logic [7:0]  shadow_regs [8];
  logic [7:0]  shadow_status;

  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errors = 0;
  string       test_name;

  // PHI2 and chip select monitors
  logic        phi2_w;
  logic        cs_b_w;
  time         rise_time = 0;
  time         high_time = 0;
  int          cs_falls = 0;

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  z80tube_top dut_i (
    .CLK           (CLK),
    .reset_b_w     (reset_b_w),
    .host          (host),
    .data_in       (data_in),
    .tube_data_in  (tube_data_in),
    .tube_int_b    (tube_int_b),
    .data_out      (data_out),
    .data_oe       (data_oe),
    .int_b         (int_b),
    .tube          (tube),
    .tube_data_out (tube_data_out),
    .tube_data_oe  (tube_data_oe)
  );

  tube_parasite_model model_i (
    .tube        (tube),
    .data_in     (tube_data_out),
    .data_out    (tube_data_in),
    .phi2_count  (phi2_count),
    .write_count (write_count)
  );

  assign phi2_w = tube.phi2;
  assign cs_b_w = tube.cs_b;

  always @(posedge phi2_w) rise_time = $time;
  always @(negedge phi2_w) high_time = $time - rise_time;
  always @(negedge cs_b_w) cs_falls = cs_falls + 1;

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    int errs;
    errs = error_count - test_start_errors;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %-16s %s, %0d errors", test_name, (errs == 0) ? "pass" : "fail", errs);
  endtask

  // One Z80 I/O cycle starting on falling edge E0
  task automatic io_cycle(input logic [15:0] adr, input logic is_wr, input logic [7:0] wdata,
                          input int waits, output logic [7:0] rdata, output logic rd_oe,
                          output logic wr_oe, output tube_bus_t snap, output time exp_rise);
    time start_t;
    int  rise_edge;
    @(negedge CLK);
    start_t = $time;
    host.adr    <= adr;
    host.iorq_b <= 1'b0;
    host.rd_b   <= is_wr;
    host.wr_b   <= !is_wr;
    host.wait_b <= (waits == 0) ? 1'b0 : 1'b1;
    data_in     <= wdata;
    // WAIT held high for the stretch and first seen low on E(waits+1)
    repeat (waits) @(negedge CLK);
    host.wait_b <= 1'b0;
    // S0 entered on E1 and left on the first later edge that sees WAIT low
    rise_edge = (waits + 1 > 2) ? waits + 1 : 2;
    repeat (rise_edge - waits) @(negedge CLK);
    // Write data driven in the late half of the first PHI2 cycle
    #(CLK_PERIOD * 3 / 4);
    wr_oe = tube_data_oe;
    @(negedge CLK);
    #(CLK_PERIOD / 4);
    rdata = data_out;
    rd_oe = data_oe;
    snap  = tube;
    // Back in IDLE so the host cycle ends
    @(negedge CLK);
    host.iorq_b <= 1'b1;
    host.rd_b   <= 1'b1;
    host.wr_b   <= 1'b1;
    host.wait_b <= 1'b1;
    exp_rise = start_t + time'(rise_edge * CLK_PERIOD);
  endtask

  task automatic regs_match();
    int i;
    for (i = 0; i < 8; i++) begin
      if (model_i.regs[i] !== shadow_regs[i]) begin
        report_mismatch($sformatf("Tube reg %0d is %h, expected %h",
                                  i, model_i.regs[i], shadow_regs[i]));
      end
    end
  endtask

  task automatic tube_access(input logic [2:0] reg_sel, input logic is_wr,
                             input logic [7:0] wdata, input int waits);
    logic [7:0]  rdata;
    logic        rd_oe;
    logic        wr_oe;
    tube_bus_t   snap;
    time         exp_rise;
    logic [31:0] count_before;
    int          cs_before;
    count_before = phi2_count;
    cs_before    = cs_falls;
    io_cycle({PORT_ID_BASE[15:4], 1'b0, reg_sel}, is_wr, wdata, waits,
             rdata, rd_oe, wr_oe, snap, exp_rise);
    if (phi2_count !== count_before + 1) begin
      report_mismatch($sformatf("PHI2 count %0d, expected %0d", phi2_count, count_before + 1));
    end
    if (cs_falls != cs_before + 1) begin
      report_mismatch("cs_b did not fall exactly once");
    end
    if (rise_time != exp_rise) begin
      report_mismatch($sformatf("PHI2 rose at %0t, expected %0t (wait %0d)",
                                rise_time, exp_rise, waits));
    end
    if (high_time != time'(CLK_PERIOD * 3 / 2)) begin
      report_mismatch($sformatf("PHI2 high for %0t ns", high_time));
    end
    if (snap.cs_b !== 1'b0 || snap.adr !== reg_sel || snap.rnw_b !== !is_wr) begin
      report_mismatch($sformatf("Tube bus cs_b %b adr %0d rnw_b %b",
                                snap.cs_b, snap.adr, snap.rnw_b));
    end
    if (is_wr) begin
      shadow_regs[reg_sel] = wdata;
      if (wr_oe !== 1'b1) begin
        report_mismatch("tube_data_oe low during Tube write");
      end
      if (model_i.regs[reg_sel] !== wdata) begin
        report_mismatch($sformatf("Tube reg %0d holds %h after write of %h",
                                  reg_sel, model_i.regs[reg_sel], wdata));
      end
    end else begin
      if (wr_oe !== 1'b0) begin
        report_mismatch("tube_data_oe high during Tube read");
      end
      if (rd_oe !== 1'b1) begin
        report_mismatch("data_oe low during Tube read");
      end
      if (rdata !== shadow_regs[reg_sel]) begin
        report_mismatch($sformatf("Tube read reg %0d gave %h, expected %h",
                                  reg_sel, rdata, shadow_regs[reg_sel]));
      end
    end
  endtask

  task automatic status_access(input logic is_wr, input logic [7:0] wdata);
    logic [7:0] rdata;
    logic       rd_oe;
    logic       wr_oe;
    tube_bus_t  snap;
    time        exp_rise;
    io_cycle({PORT_ID_BASE[15:4], STATUS_PORT_LSB}, is_wr, wdata, 0,
             rdata, rd_oe, wr_oe, snap, exp_rise);
    if (is_wr) begin
      shadow_status = wdata;
    end else begin
      if (rd_oe !== 1'b1) begin
        report_mismatch("data_oe low during status read");
      end
      if (rdata !== shadow_status) begin
        report_mismatch($sformatf("Status read %h, expected %h", rdata, shadow_status));
      end
    end
  endtask

  task automatic unselected_access(input logic [15:0] adr, input logic is_wr,
                                   input logic [7:0] wdata, input int waits);
    logic [7:0]  rdata;
    logic        rd_oe;
    logic        wr_oe;
    tube_bus_t   snap;
    time         exp_rise;
    logic [31:0] count_before;
    logic [31:0] writes_before;
    int          cs_before;
    count_before  = phi2_count;
    writes_before = write_count;
    cs_before     = cs_falls;
    io_cycle(adr, is_wr, wdata, waits, rdata, rd_oe, wr_oe, snap, exp_rise);
    if (cs_falls != cs_before || snap.cs_b !== 1'b1) begin
      report_mismatch($sformatf("cs_b went low for port %h", adr));
    end
    if (phi2_count !== count_before || write_count !== writes_before) begin
      report_mismatch($sformatf("PHI2 pulse for port %h", adr));
    end
    if (rd_oe !== 1'b0) begin
      report_mismatch($sformatf("data_oe high for port %h", adr));
    end
    regs_match();
  endtask

  initial begin
    int         i;
    int         w;
    logic [7:0] v;
    logic [2:0] r;
    logic [15:0] a;
    void'($urandom(32'h149));
    reset_b_w   = 1'b0;
    host        = '{adr: 16'h0000, rd_b: 1'b1, wr_b: 1'b1, iorq_b: 1'b1, wait_b: 1'b1};
    data_in     = 8'h00;
    // Tube interrupt asserted so the reset check sees the gate closed
    tube_int_b  = 1'b0;
    shadow_status = 8'h00;
    for (i = 0; i < 8; i++) begin
      shadow_regs[i] = 8'h5A ^ 8'(i * 37);
    end

    // Idle outputs while reset is held
    begin_test("after_reset");
    repeat (RESET_CYCLES / 2) @(negedge CLK);
    #(CLK_PERIOD / 4);
    if (tube.phi2 !== 1'b0 || tube.cs_b !== 1'b1 || tube.rst_b !== 1'b0) begin
      report_mismatch("Tube bus not idle in reset");
    end
    if (data_oe !== 1'b0 || tube_data_oe !== 1'b0 || int_b !== 1'b1) begin
      report_mismatch("Enables or int_b active in reset");
    end
    repeat (RESET_CYCLES - RESET_CYCLES / 2) @(negedge CLK);
    reset_b_w <= 1'b1;
    repeat (2) @(negedge CLK);
    #(CLK_PERIOD / 4);
    if (tube.rst_b !== 1'b1 || tube.phi2 !== 1'b0 || tube.cs_b !== 1'b1) begin
      report_mismatch("Tube bus wrong after reset");
    end
    if (data_oe !== 1'b0 || tube_data_oe !== 1'b0) begin
      report_mismatch("Enables active after reset");
    end
    status_access(1'b0, 8'h00);
    end_test();

    begin_test("tube_writes");
    for (i = 0; i < 40; i++) begin
      tube_access(3'($urandom), 1'b1, 8'($urandom), int'($urandom % 32'd4));
    end
    regs_match();
    end_test();

    // Reads mixed with about one write in three
    begin_test("tube_reads");
    for (i = 0; i < 40; i++) begin
      r = 3'($urandom);
      w = int'($urandom % 32'd4);
      if (($urandom % 32'd3) == 32'd0) begin
        tube_access(r, 1'b1, 8'($urandom), w);
      end else begin
        tube_access(r, 1'b0, 8'h00, w);
      end
    end
    end_test();

    begin_test("status_register");
    for (i = 0; i < 16; i++) begin
      v = 8'($urandom);
      @(negedge CLK);
      tube_int_b <= 1'($urandom);
      status_access(1'b1, v);
      status_access(1'b0, 8'h00);
      if (tube.rst_b !== !v[STAT_TUBE_RESET_BIT]) begin
        report_mismatch($sformatf("Tube rst_b %b with status %h", tube.rst_b, v));
      end
      if (int_b !== !(v[STAT_INT_ENABLE_BIT] && !tube_int_b)) begin
        report_mismatch($sformatf("int_b %b, status %h, tube_int_b %b", int_b, v, tube_int_b));
      end
    end
    @(negedge CLK);
    tube_int_b <= 1'b1;
    status_access(1'b1, 8'h00);
    end_test();

    // Ports outside the block or in the gap FC18 to FC1E
    begin_test("unselected_ports");
    for (i = 0; i < 24; i++) begin
      if (1'($urandom)) begin
        a = 16'hFC18 + 16'($urandom % 32'd7);
      end else begin
        a = 16'($urandom);
        if (a[15:4] == PORT_ID_BASE[15:4]) begin
          a[15:4] = ~a[15:4];
        end
      end
      unselected_access(a, 1'($urandom), 8'($urandom), int'($urandom % 32'd4));
    end
    status_access(1'b0, 8'h00);
    end_test();

    begin_test("phi2_width");
    for (i = 0; i < 20; i++) begin
      tube_access(3'($urandom), 1'($urandom), 8'($urandom), int'($urandom % 32'd4));
    end
    end_test();

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Stops a run whose handshake never completes
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tube_parasite_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tube_parasite_model import z80tube_pkg::*; (
  input  tube_bus_t   tube,
  input  logic [7:0]  data_in,
  output logic [7:0]  data_out,
  output logic [31:0] phi2_count,
  output logic [31:0] write_count
);

  // Eight parasite-side Tube registers
  logic [7:0]  regs [8];
  logic [31:0] phi2_count_q = '0;
  logic [31:0] write_count_q = '0;
  logic        phi2;
  int          idx;

  assign phi2 = tube.phi2;

  // Power-up contents, a distinct byte per register address
  initial begin
    for (idx = 0; idx < 8; idx++) begin
      regs[idx] = 8'h5A ^ 8'(idx * 37);
    end
  end

  // Every PHI2 pulse is one Tube bus cycle
  always @(posedge phi2) begin
    phi2_count_q <= phi2_count_q + 1;
  end

  // Write data taken on the trailing edge of PHI2
  always @(negedge phi2) begin
    if (!tube.cs_b && !tube.rnw_b) begin
      regs[tube.adr] <= data_in;
      write_count_q  <= write_count_q + 1;
    end
  end

  // Read data driven whenever selected for a read
  assign data_out = (!tube.cs_b && tube.rnw_b) ? regs[tube.adr] : 8'h00;

  assign phi2_count  = phi2_count_q;
  assign write_count = write_count_q;

endmodule

`default_nettype wire

/* source/z80tube_top.sv */
`timescale 1ns/1ps
`default_nettype none

module z80tube_top import z80tube_pkg::*; (
  input  logic       CLK,
  input  logic       reset_b_w,
  input  host_bus_t  host,
  input  logic [7:0] data_in,
  input  logic [7:0] tube_data_in,
  input  logic       tube_int_b,
  output logic [7:0] data_out,
  output logic       data_oe,
  output logic       int_b,
  output tube_bus_t  tube,
  output logic [7:0] tube_data_out,
  output logic       tube_data_oe
);

  port_sel_t  sel;
  tube_bus_t  tube_ctl;
  logic [7:0] status;
  logic       phi2;
  logic       tube_rst_b;

  // Address decode and host read path
  host_bus_interface host_if_i (
    .host         (host),
    .tube_data_in (tube_data_in),
    .status       (status),
    .sel          (sel),
    .tube_ctl     (tube_ctl),
    .data_out     (data_out),
    .data_oe      (data_oe)
  );

  // PHI2 generation and Tube data direction
  tube_cycle_sequencer seq_i (
    .CLK          (CLK),
    .reset_b_w    (reset_b_w),
    .host         (host),
    .sel          (sel),
    .phi2         (phi2),
    .tube_data_oe (tube_data_oe)
  );

  // Status byte, Tube reset and interrupt gate
  bridge_control_regs ctrl_i (
    .CLK        (CLK),
    .reset_b_w  (reset_b_w),
    .host       (host),
    .sel        (sel),
    .data_in    (data_in),
    .tube_int_b (tube_int_b),
    .status     (status),
    .tube_rst_b (tube_rst_b),
    .int_b      (int_b)
  );

  // Assemble the Tube port from its three sources
  assign tube.adr   = tube_ctl.adr;
  assign tube.rnw_b = tube_ctl.rnw_b;
  assign tube.cs_b  = tube_ctl.cs_b;
  assign tube.phi2  = phi2;
  assign tube.rst_b = tube_rst_b;

  // Host write data goes straight to the Tube bus
  assign tube_data_out = data_in;

endmodule

`default_nettype wire

/* source/bridge_control_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_control_regs import z80tube_pkg::*; (
  input  logic       CLK,
  input  logic       reset_b_w,
  input  host_bus_t  host,
  input  port_sel_t  sel,
  input  logic [7:0] data_in,
  input  logic       tube_int_b,
  output logic [7:0] status,
  output logic       tube_rst_b,
  output logic       int_b
);

  logic [7:0] status_q;
  logic [7:0] status_d;
  logic       status_wr;
  logic       tube_rst_b_q;

  // Host I/O write to FC1F
  assign status_wr = sel.status_sel && !host.iorq_b && !host.wr_b;

  // Next status value, shared by the byte and the reset flop
  always_comb begin
    status_d = status_q;
    if (status_wr) begin
      status_d = data_in;
    end
  end

  // Written on the falling edge while host data is valid
  always_ff @(negedge CLK) begin
    if (!reset_b_w) begin
      status_q     <= 8'h00;
      tube_rst_b_q <= 1'b0;
    end else begin
      status_q     <= status_d;
      // Tube held in reset while bit 7 is set
      tube_rst_b_q <= !status_d[STAT_TUBE_RESET_BIT];
    end
  end

  assign status     = status_q;
  assign tube_rst_b = tube_rst_b_q;

  // Forward the Tube interrupt only when enabled by bit 6
  assign int_b = !(status_q[STAT_INT_ENABLE_BIT] && !tube_int_b);

endmodule

`default_nettype wire

/* source/tube_cycle_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tube_cycle_sequencer import z80tube_pkg::*; (
  input  logic      CLK,
  input  logic      reset_b_w,
  input  host_bus_t host,
  input  port_sel_t sel,
  output logic      phi2,
  output logic      tube_data_oe
);

  // Falling-edge view of one access
  //   state    IDLE | S0 ... S0 | S1 | S2 | IDLE
  //   negen_f_q      set leaving S0, clear leaving S1
  //   posen_q        same, half a CLK later
  //   phi2           OR of both, 1.5 CLK wide

  tube_state_e state_f_q;
  tube_state_e state_d;
  logic        negen_f_q;
  logic        posen_q;
  logic        wr_b_q;
  logic        done_f_q;
  logic        tube_access;

  // Tube access requested and not yet served in this host cycle
  assign tube_access = !host.iorq_b && sel.tube_sel && !done_f_q;

  always_comb begin
    state_d = state_f_q;
    case (state_f_q)
      IDLE: begin
        if (tube_access) begin
          state_d = S0;
        end
      end
      // Host stretches the cycle here with WAIT
      S0: begin
        if (!host.wait_b) begin
          state_d = S1;
        end
      end
      S1: state_d = S2;
      S2: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(negedge CLK) begin
    if (!reset_b_w) begin
      state_f_q <= IDLE;
      negen_f_q <= 1'b0;
      done_f_q  <= 1'b0;
    end else begin
      state_f_q <= state_d;
      // Rising PHI2 on the edge that leaves S0
      if ((state_f_q == S0) && !host.wait_b) begin
        negen_f_q <= 1'b1;
      end else if (state_f_q == S1) begin
        negen_f_q <= 1'b0;
      end
      // Block a second pulse until IORQ goes high again
      if (state_f_q == S2) begin
        done_f_q <= 1'b1;
      end else if (host.iorq_b) begin
        done_f_q <= 1'b0;
      end
    end
  end

  // Rising-edge copy stretches PHI2 by half a clock
  always_ff @(posedge CLK) begin
    if (!reset_b_w) begin
      posen_q <= 1'b0;
      wr_b_q  <= 1'b1;
    end else begin
      posen_q <= negen_f_q;
      wr_b_q  <= host.wr_b;
    end
  end

  // Built from flop outputs only, so no decode glitches
  assign phi2 = negen_f_q || posen_q;

  // Drive Tube data for writes in the late part of the pulse
  assign tube_data_oe = !wr_b_q && posen_q &&
                        ((state_f_q == S1) || (state_f_q == S2));

endmodule

`default_nettype wire

/* source/host_bus_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module host_bus_interface import z80tube_pkg::*; (
  input  host_bus_t  host,
  input  logic [7:0] tube_data_in,
  input  logic [7:0] status,
  output port_sel_t  sel,
  output tube_bus_t  tube_ctl,
  output logic [7:0] data_out,
  output logic       data_oe
);

  logic port_match;
  logic io_read;

  // Upper twelve address bits pick the sixteen-port block
  assign port_match = (host.adr[15:4] == PORT_ID_BASE[15:4]);

  // FC1F is the local status byte
  assign sel.status_sel = port_match && (host.adr[3:0] == STATUS_PORT_LSB);

  // FC10 to FC17 map onto the eight Tube registers
  assign sel.tube_sel = port_match && !host.adr[3];

  // Z80 I/O read in progress
  assign io_read = !host.iorq_b && !host.rd_b;

  // Chip select follows IORQ while the Tube window is addressed
  assign tube_ctl.cs_b = host.iorq_b || !sel.tube_sel;

  // Read unless an I/O write is under way
  assign tube_ctl.rnw_b = host.iorq_b || host.wr_b;

  // Register address passes straight through
  assign tube_ctl.adr = host.adr[TUBE_ADR_W-1:0];

  // PHI2 and reset come from other blocks, parked at their idle levels here
  assign tube_ctl.phi2  = 1'b0;
  assign tube_ctl.rst_b = 1'b1;

  // Host drives the data bus only for reads of our own ports
  assign data_oe = io_read && (sel.status_sel || sel.tube_sel);

  // Read data mux, status port wins since it never overlaps the Tube window
  always_comb begin
    if (sel.status_sel) begin
      data_out = status;
    end else begin
      data_out = tube_data_in;
    end
  end

endmodule

`default_nettype wire

/* source/z80tube_pkg.sv */
`default_nettype none

package z80tube_pkg;

  // Card I/O block, matched in address bits 15 down to 4
  localparam logic [15:0] PORT_ID_BASE = 16'hFC10;

  // Low nibble of the local status and control port
  localparam logic [3:0] STATUS_PORT_LSB = 4'hF;

  // Tube register address width, eight registers
  localparam int TUBE_ADR_W = 3;

  // Status byte bit positions
  localparam int STAT_TUBE_RESET_BIT = 7;
  localparam int STAT_INT_ENABLE_BIT = 6;

  // Tube cycle sequencer states, updated on the falling CLK edge
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    S0   = 2'd1,
    S1   = 2'd2,
    S2   = 2'd3
  } tube_state_e;

  // Z80 host bus, all strobes active low
  typedef struct packed {
    logic [15:0] adr;
    logic        rd_b;
    logic        wr_b;
    logic        iorq_b;
    logic        wait_b;
  } host_bus_t;

  // Tube parasite port control lines
  typedef struct packed {
    logic [TUBE_ADR_W-1:0] adr;
    logic                  rnw_b;
    logic                  phi2;
    logic                  cs_b;
    logic                  rst_b;
  } tube_bus_t;

  // Port decode result
  typedef struct packed {
    logic status_sel;
    logic tube_sel;
  } port_sel_t;

endpackage

`default_nettype wire
